// File: cpu16.f
source/cpu16_pkg.sv
source/stage_if.sv
source/fetch.sv
source/decode.sv
source/hazard_unit.sv
source/execute.sv
source/memory_wb.sv
source/proc.sv
test/proc_properties.sv
test/proc_tb.sv

// File: Makefile
# Verilator build for the cpu16 pipeline
# override any variable on the command line, e.g. make sim TOP=proc_tb

VERILATOR ?= verilator
TOP       ?= proc_tb
FILELIST  ?= cpu16.f
FLAGS     ?= --timing --assert -Wno-fatal
BUILD_DIR ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the simulator exits non-zero on $fatal, so make fails with it
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: test/proc_tb.sv
// ###################
// cpu16 testbench
// runs two programs and compares the write-back trace
// ###################
`timescale 1ns/1ps

module proc_tb
   import cpu16_pkg::*;
();

   localparam int period          = 100;
   localparam int reset_cycles    = 8;
   localparam int idle_cycles     = 10;
   localparam int rom_depth       = 32;
   localparam int trace_depth     = 16;
   localparam int main_len        = 17;
   localparam int error_len       = 4;
   localparam int watchdog_cycles = (main_len + error_len) * 20
                                  + 2 * (reset_cycles + idle_cycles + 2);
   localparam logic [15:0] nop_word = 16'h0000;

   logic        clk;
   logic        rst;
   logic [15:0] imem_data;
   logic        dmem_ready;
   logic [15:0] dmem_rdata;
   logic [15:0] imem_addr;
   logic        dmem_valid;
   logic        dmem_write;
   logic [15:0] dmem_addr;
   logic [15:0] dmem_wdata;
   logic        wb_valid;
   logic [2:0]  wb_dst;
   logic [15:0] wb_data;
   logic        halt;
   logic        err;

   // program rom and expected register writes, in order
   logic [15:0] rom [rom_depth];
   logic [2:0]  exp_dst [trace_depth];
   logic [15:0] exp_data [trace_depth];
   logic [15:0] dmem [64];
   int          prog_len;
   int          exp_len;
   int          beats;
   int          seed;
   int          rnd;

   proc uut (
      .clk        (clk),
      .rst        (rst),
      .imem_data  (imem_data),
      .dmem_ready (dmem_ready),
      .dmem_rdata (dmem_rdata),
      .imem_addr  (imem_addr),
      .dmem_valid (dmem_valid),
      .dmem_write (dmem_write),
      .dmem_addr  (dmem_addr),
      .dmem_wdata (dmem_wdata),
      .wb_valid   (wb_valid),
      .wb_dst     (wb_dst),
      .wb_data    (wb_data),
      .halt       (halt),
      .err        (err)
   );

   always #(period / 2) clk = ~clk;

   function automatic logic [15:0] encode_reg_op(input opcode_e op, input logic [2:0] rd,
                                                 input logic [2:0] rs, input logic [2:0] rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic logic [15:0] encode_short_imm(input opcode_e op, input logic [2:0] rd,
                                                    input logic [2:0] rs, input int imm);
      return {op, rd, rs, 6'(imm)};
   endfunction

   function automatic logic [15:0] encode_long_imm(input opcode_e op, input logic [2:0] rd,
                                                   input int imm);
      return {op, rd, 9'(imm)};
   endfunction

   // rom read by word address with nop past the end of the program
   function automatic logic [15:0] rom_word(input logic [15:0] addr);
      logic [15:0] word;
      if (int'(addr[15:1]) < prog_len) begin
         word = rom[addr[5:1]];
      end else begin
         word = nop_word;
      end
      return word;
   endfunction

   task automatic add_instr(input logic [15:0] word);
      rom[prog_len] = word;
      prog_len++;
   endtask

   task automatic expect_write(input logic [2:0] dst, input logic [15:0] data);
      exp_dst[exp_len]  = dst;
      exp_data[exp_len] = data;
      exp_len++;
   endtask

   task automatic clear_tables();
      prog_len = 0;
      exp_len  = 0;
      for (int i = 0; i < rom_depth; i++) begin
         rom[i] = nop_word;
      end
   endtask

   task automatic load_main_program();
      clear_tables();
      add_instr(encode_long_imm(op_lbi, 3'd1, 5));
      expect_write(3'd1, 16'd5);
      add_instr(encode_long_imm(op_lbi, 3'd2, 3));
      expect_write(3'd2, 16'd3);
      // both forwarding paths
      add_instr(encode_reg_op(op_add, 3'd3, 3'd1, 3'd2));
      expect_write(3'd3, 16'd5 + 16'd3);
      add_instr(encode_reg_op(op_sub, 3'd4, 3'd3, 3'd1));
      expect_write(3'd4, 16'd8 - 16'd5);
      add_instr(encode_reg_op(op_and, 3'd5, 3'd3, 3'd4));
      expect_write(3'd5, 16'd8 & 16'd3);
      add_instr(encode_reg_op(op_xor, 3'd6, 3'd3, 3'd4));
      expect_write(3'd6, 16'd8 ^ 16'd3);
      add_instr(encode_short_imm(op_addi, 3'd7, 3'd6, -2));
      expect_write(3'd7, 16'd11 - 16'd2);
      // store then load at r1 + 3
      add_instr(encode_short_imm(op_st, 3'd7, 3'd1, 3));
      add_instr(encode_short_imm(op_ld, 3'd0, 3'd1, 3));
      expect_write(3'd0, 16'd9);
      // load-use bubble
      add_instr(encode_reg_op(op_add, 3'd2, 3'd0, 3'd7));
      expect_write(3'd2, 16'd9 + 16'd9);
      // r5 is zero, so the two lbi below are skipped
      add_instr(encode_long_imm(op_beqz, 3'd5, 2));
      add_instr(encode_long_imm(op_lbi, 3'd3, 16'h55));
      add_instr(encode_long_imm(op_lbi, 3'd4, 16'h66));
      add_instr(encode_long_imm(op_beqz, 3'd1, 5));
      add_instr(encode_short_imm(op_addi, 3'd3, 3'd2, 1));
      expect_write(3'd3, 16'd18 + 16'd1);
      add_instr({op_halt, 12'h000});
      add_instr(encode_long_imm(op_lbi, 3'd6, 7));
   endtask

   task automatic load_error_program();
      clear_tables();
      add_instr(encode_long_imm(op_lbi, 3'd1, 1));
      expect_write(3'd1, 16'd1);
      add_instr(encode_reg_op(op_add, 3'd2, 3'd1, 3'd1));
      expect_write(3'd2, 16'd1 + 16'd1);
      // opcode 4'ha is not defined
      add_instr(16'ha000);
      add_instr({op_halt, 12'h000});
   endtask

   task automatic fill_data_memory();
      for (int i = 0; i < 64; i++) begin
         dmem[i] = 16'hc3a5 ^ (16'(i) * 16'h0101);
      end
   endtask

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
                              input string what);
      if (actual !== expected) begin
         report_failure($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                                  $time, what, actual, expected));
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #1;
      rst = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      #1;
      rst = 1'b0;
   endtask

   task automatic sample_trace();
      if (wb_valid) begin
         if (beats >= exp_len) begin
            report_failure($sformatf("unexpected write-back to r%0d at %0t ns", wb_dst, $time));
         end else begin
            check_value(16'(wb_dst), 16'(exp_dst[beats]), "wb_dst");
            check_value(wb_data, exp_data[beats], "wb_data");
            beats++;
         end
      end else if (halt && beats < exp_len) begin
         report_failure($sformatf("halt raised after only %0d of %0d write-backs",
                                  beats, exp_len));
      end
   endtask

   task automatic run_until_halt();
      bit done;
      done  = 1'b0;
      beats = 0;
      while (!done) begin
         @(negedge clk);
         sample_trace();
         done = (beats == exp_len) && halt;
      end
      // nothing may write back once halted
      repeat (idle_cycles) begin
         @(negedge clk);
         sample_trace();
      end
   endtask

   // inputs change 1 ns after the rising edge
   always @(posedge clk) begin
      #1;
      rnd        = $random(seed);
      imem_data  = rom_word(imem_addr);
      dmem_ready = rnd[0];
      dmem_rdata = dmem[dmem_addr[6:1]];
   end

   // stores land on a transfer cycle
   always @(negedge clk) begin
      if (!rst && dmem_valid && dmem_ready && dmem_write) begin
         dmem[dmem_addr[6:1]] = dmem_wdata;
      end
   end

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      report_failure($sformatf("timeout, halt not reached within %0d cycles", watchdog_cycles));
   end

   initial begin
      seed       = 32'h2926_6f60;
      clk        = 1'b0;
      rst        = 1'b1;
      imem_data  = nop_word;
      dmem_ready = 1'b0;
      dmem_rdata = 16'h0000;
      fill_data_memory();
      load_main_program();
      apply_reset();
      run_until_halt();
      // st put r7 at byte address r1 + 3
      check_value(dmem[(5 + 3) / 2], 16'd9, "data memory word at r1 + 3");
      check_value(16'(err), 16'd0, "err after the main program");
      // pipeline is halted, so the rom can be swapped before reset
      load_error_program();
      apply_reset();
      run_until_halt();
      check_value(16'(err), 16'd1, "err after the illegal opcode");
      $display("Everything OK");
      $finish;
   end

endmodule

// File: test/proc_properties.sv
// ###################
// memory_wb properties
// dmem handshake, reset values and halt behavior
// ###################
`timescale 1ns/1ps

module proc_properties
   import cpu16_pkg::*;
(
   input logic              clk,
   input logic              rst,
   input logic              dmem_valid,
   input logic              dmem_ready,
   input logic              dmem_write,
   input logic [data_w-1:0] dmem_addr,
   input logic [data_w-1:0] dmem_wdata,
   input logic              wb_valid,
   input logic              halt
);

   // a waiting request keeps its fields until the transfer
   property request_held;
      @(posedge clk) disable iff (rst)
         dmem_valid && !dmem_ready |=> dmem_valid && $stable(dmem_write)
            && $stable(dmem_addr) && $stable(dmem_wdata);
   endproperty

   property reset_clears;
      @(posedge clk) rst |=> !wb_valid && !dmem_valid && !halt;
   endproperty

   property quiet_after_halt;
      @(posedge clk) disable iff (rst) halt |-> !wb_valid;
   endproperty

   assert property (request_held)
      else $error("dmem request changed while waiting for ready");
   assert property (reset_clears)
      else $error("wb_valid, dmem_valid or halt high during reset");
   assert property (quiet_after_halt)
      else $error("register write-back after halt");

endmodule

bind memory_wb proc_properties props (
   .clk        (clk),
   .rst        (rst),
   .dmem_valid (dmem_valid),
   .dmem_ready (dmem_ready),
   .dmem_write (dmem_write),
   .dmem_addr  (dmem_addr),
   .dmem_wdata (dmem_wdata),
   .wb_valid   (wb_valid),
   .halt       (halt)
);

// File: source/proc.sv
// ###################
// cpu16 top level
// five-stage pipeline with memory and trace ports
// ###################
`timescale 1ns/1ps

module proc
   import cpu16_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic [data_w-1:0] imem_data,
   input  logic              dmem_ready,
   input  logic [data_w-1:0] dmem_rdata,
   output logic [data_w-1:0] imem_addr,
   output logic              dmem_valid,
   output logic              dmem_write,
   output logic [data_w-1:0] dmem_addr,
   output logic [data_w-1:0] dmem_wdata,
   output logic              wb_valid,
   output logic [reg_w-1:0]  wb_dst,
   output logic [data_w-1:0] wb_data,
   output logic              halt,
   output logic              err
);

   logic              if_valid;
   logic [data_w-1:0] if_instr;
   logic [data_w-1:0] if_pc_plus_two;
   logic              load_stall;
   logic              mem_stall;
   logic              flush;
   logic [data_w-1:0] redirect_pc;
   logic              exmem_fwd_valid;
   logic [reg_w-1:0]  exmem_fwd_dst;
   logic [data_w-1:0] exmem_fwd_data;

   stage_if id_ex ();
   stage_if ex_mem ();

   fetch fetch0 (
      .clk            (clk),
      .rst            (rst),
      .stall          (load_stall | mem_stall),
      .flush          (flush),
      .redirect_pc    (redirect_pc),
      .halt           (halt),
      .imem_data      (imem_data),
      .imem_addr      (imem_addr),
      .if_valid       (if_valid),
      .if_instr       (if_instr),
      .if_pc_plus_two (if_pc_plus_two)
   );

   decode decode0 (
      .clk            (clk),
      .rst            (rst),
      .if_valid       (if_valid),
      .if_instr       (if_instr),
      .if_pc_plus_two (if_pc_plus_two),
      .load_stall     (load_stall),
      .mem_stall      (mem_stall),
      .flush          (flush),
      .wb_valid       (wb_valid),
      .wb_dst         (wb_dst),
      .wb_data        (wb_data),
      .err            (err),
      .out            (id_ex.src)
   );

   // load in execute against the instruction in decode
   hazard_unit hazard0 (
      .id_instr   (if_instr),
      .id_valid   (if_valid),
      .ex_op      (id_ex.op),
      .ex_rd      (id_ex.rd),
      .ex_valid   (id_ex.valid),
      .load_stall (load_stall)
   );

   execute execute0 (
      .clk             (clk),
      .rst             (rst),
      .mem_stall       (mem_stall),
      .in              (id_ex.dst),
      .exmem_fwd_valid (exmem_fwd_valid),
      .exmem_fwd_dst   (exmem_fwd_dst),
      .exmem_fwd_data  (exmem_fwd_data),
      .wb_valid        (wb_valid),
      .wb_dst          (wb_dst),
      .wb_data         (wb_data),
      .out             (ex_mem.src),
      .flush           (flush),
      .redirect_pc     (redirect_pc)
   );

   memory_wb memory_wb0 (
      .clk             (clk),
      .rst             (rst),
      .in              (ex_mem.dst),
      .dmem_ready      (dmem_ready),
      .dmem_rdata      (dmem_rdata),
      .dmem_valid      (dmem_valid),
      .dmem_write      (dmem_write),
      .dmem_addr       (dmem_addr),
      .dmem_wdata      (dmem_wdata),
      .mem_stall       (mem_stall),
      .exmem_fwd_valid (exmem_fwd_valid),
      .exmem_fwd_dst   (exmem_fwd_dst),
      .exmem_fwd_data  (exmem_fwd_data),
      .wb_valid        (wb_valid),
      .wb_dst          (wb_dst),
      .wb_data         (wb_data),
      .halt            (halt)
   );

endmodule

// File: source/memory_wb.sv
// ###################
// memory and write-back
// data memory handshake, MEM/WB register and halt
// ###################
`timescale 1ns/1ps

module memory_wb
   import cpu16_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   stage_if.dst              in,
   input  logic              dmem_ready,
   input  logic [data_w-1:0] dmem_rdata,
   output logic              dmem_valid,
   output logic              dmem_write,
   output logic [data_w-1:0] dmem_addr,
   output logic [data_w-1:0] dmem_wdata,
   output logic              mem_stall,
   output logic              exmem_fwd_valid,
   output logic [reg_w-1:0]  exmem_fwd_dst,
   output logic [data_w-1:0] exmem_fwd_data,
   output logic              wb_valid,
   output logic [reg_w-1:0]  wb_dst,
   output logic [data_w-1:0] wb_data,
   output logic              halt
);

   logic              retire;
   logic [data_w-1:0] wb_sel;

   // request fields come straight from EX/MEM, which is frozen while waiting
   assign dmem_valid = in.valid && (in.op == op_ld || in.op == op_st);
   assign dmem_write = in.op == op_st;
   assign dmem_addr  = in.result;
   assign dmem_wdata = in.b;
   assign mem_stall  = dmem_valid && !dmem_ready;

   assign retire = in.valid && !mem_stall;

   // load data is not ready yet, so only alu writers forward from here
   assign exmem_fwd_valid = in.valid && in.wb_src == wb_alu;
   assign exmem_fwd_dst   = in.rd;
   assign exmem_fwd_data  = in.result;

   assign wb_sel = (in.wb_src == wb_mem) ? dmem_rdata : in.result;

   always_ff @(posedge clk) begin
      if (rst) begin
         wb_valid <= 1'b0;
         halt     <= 1'b0;
      end else begin
         wb_valid <= retire && in.wb_src != wb_none;
         if (retire && in.op == op_halt) begin
            halt <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      wb_dst  <= in.rd;
      wb_data <= wb_sel;
   end

endmodule

// File: source/execute.sv
// ###################
// execute stage
// forwarding, ALU, branch resolve and EX/MEM register
// ###################
`timescale 1ns/1ps

module execute
   import cpu16_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              mem_stall,
   stage_if.dst              in,
   input  logic              exmem_fwd_valid,
   input  logic [reg_w-1:0]  exmem_fwd_dst,
   input  logic [data_w-1:0] exmem_fwd_data,
   input  logic              wb_valid,
   input  logic [reg_w-1:0]  wb_dst,
   input  logic [data_w-1:0] wb_data,
   stage_if.src              out,
   output logic              flush,
   output logic [data_w-1:0] redirect_pc
);

   fwd_sel_e          sel_a;
   fwd_sel_e          sel_b;
   logic [data_w-1:0] a_val;
   logic [data_w-1:0] b_val;
   logic [data_w-1:0] alu_res;
   logic              taken;

   // youngest producer wins
   function automatic fwd_sel_e pick_fwd(input logic [reg_w-1:0] src);
      fwd_sel_e sel;
      if (exmem_fwd_valid && exmem_fwd_dst == src) begin
         sel = fwd_exmem;
      end else if (wb_valid && wb_dst == src) begin
         sel = fwd_memwb;
      end else begin
         sel = fwd_reg;
      end
      return sel;
   endfunction

   function automatic logic [data_w-1:0] fwd_value(input fwd_sel_e sel,
                                                   input logic [data_w-1:0] reg_val);
      case (sel)
         fwd_exmem: return exmem_fwd_data;
         fwd_memwb: return wb_data;
         default:   return reg_val;
      endcase
   endfunction

   always_comb begin
      sel_a = pick_fwd(in.rs);
      sel_b = pick_fwd(in.rt);
      a_val = fwd_value(sel_a, in.a);
      b_val = fwd_value(sel_b, in.b);
   end

   always_comb begin
      case (in.op)
         op_add:       alu_res = a_val + b_val;
         op_sub:       alu_res = a_val - b_val;
         op_and:       alu_res = a_val & b_val;
         op_xor:       alu_res = a_val ^ b_val;
         op_lbi:       alu_res = in.imm;
         // addi and the load/store address share the adder
         op_addi, op_ld, op_st: alu_res = a_val + in.imm;
         default:      alu_res = '0;
      endcase
   end

   // not-taken prediction, redirect only when the branch leaves execute
   assign taken       = in.valid && in.op == op_beqz && a_val == '0;
   assign flush       = taken && !mem_stall;
   assign redirect_pc = in.pc_plus_two + {in.imm[data_w-2:0], 1'b0};

   always_ff @(posedge clk) begin
      if (rst) begin
         out.valid <= 1'b0;
      end else if (!mem_stall) begin
         out.valid <= in.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (!mem_stall) begin
         out.op          <= in.op;
         out.rd          <= in.rd;
         out.rs          <= in.rs;
         out.rt          <= in.rt;
         out.a           <= a_val;
         // store data rides in b
         out.b           <= b_val;
         out.imm         <= in.imm;
         out.pc_plus_two <= in.pc_plus_two;
         out.wb_src      <= in.wb_src;
         out.result      <= alu_res;
      end
   end

endmodule

// File: source/hazard_unit.sv
// ###################
// hazard unit
// one-cycle stall for a load followed by a dependent instruction
// ###################
`timescale 1ns/1ps

module hazard_unit
   import cpu16_pkg::*;
(
   input  logic [data_w-1:0] id_instr,
   input  logic              id_valid,
   input  opcode_e           ex_op,
   input  logic [reg_w-1:0]  ex_rd,
   input  logic              ex_valid,
   output logic              load_stall
);

   opcode_e id_op;
   logic    uses_rs;
   logic    uses_rt;
   logic    uses_rd;
   logic    hit;

   assign id_op = opcode_e'(id_instr[op_lsb +: op_w]);

   // which fields the decoding instruction actually reads
   always_comb begin
      uses_rs = id_op inside {op_add, op_sub, op_and, op_xor, op_addi, op_ld, op_st};
      uses_rt = id_op inside {op_add, op_sub, op_and, op_xor};
      uses_rd = id_op inside {op_st, op_beqz};
   end

   assign hit = (uses_rs && id_instr[rs_lsb +: reg_w] == ex_rd)
             || (uses_rt && id_instr[rt_lsb +: reg_w] == ex_rd)
             || (uses_rd && id_instr[rd_lsb +: reg_w] == ex_rd);

   assign load_stall = id_valid && ex_valid && ex_op == op_ld && hit;

endmodule

// File: source/decode.sv
// ###################
// instruction decode
// field split, register file read, control and ID/EX register
// ###################
`timescale 1ns/1ps

module decode
   import cpu16_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              if_valid,
   input  logic [data_w-1:0] if_instr,
   input  logic [data_w-1:0] if_pc_plus_two,
   input  logic              load_stall,
   input  logic              mem_stall,
   input  logic              flush,
   input  logic              wb_valid,
   input  logic [reg_w-1:0]  wb_dst,
   input  logic [data_w-1:0] wb_data,
   output logic              err,
   stage_if.src              out
);

   logic [data_w-1:0] regs [reg_count];
   opcode_e           op;
   logic [reg_w-1:0]  rd;
   logic [reg_w-1:0]  ra;
   logic [reg_w-1:0]  rb;
   logic [data_w-1:0] imm6_ext;
   logic [data_w-1:0] imm9_ext;
   logic [data_w-1:0] rd_a;
   logic [data_w-1:0] rd_b;
   wb_src_e           wb_src;
   logic              legal;
   logic              halt_seen;
   logic              issue;

   assign op = opcode_e'(if_instr[op_lsb +: op_w]);
   assign rd = if_instr[rd_lsb +: reg_w];

   assign imm6_ext = {{(data_w - imm6_w){if_instr[imm6_w-1]}}, if_instr[imm6_w-1:0]};
   assign imm9_ext = {{(data_w - imm9_w){if_instr[imm9_w-1]}}, if_instr[imm9_w-1:0]};

   // beqz tests rd, st stores rd
   assign ra = (op == op_beqz) ? rd : if_instr[rs_lsb +: reg_w];
   assign rb = (op == op_st) ? rd : if_instr[rt_lsb +: reg_w];

   always_comb begin
      legal = 1'b1;
      case (op)
         op_add, op_sub, op_and, op_xor, op_addi, op_lbi: wb_src = wb_alu;
         op_ld: wb_src = wb_mem;
         op_nop, op_st, op_beqz, op_halt: wb_src = wb_none;
         default: begin
            wb_src = wb_none;
            legal  = 1'b0;
         end
      endcase
   end

   // register file, a same-cycle write is seen by the read
   assign rd_a = (wb_valid && wb_dst == ra) ? wb_data : regs[ra];
   assign rd_b = (wb_valid && wb_dst == rb) ? wb_data : regs[rb];

   always_ff @(posedge clk) begin
      if (wb_valid) begin
         regs[wb_dst] <= wb_data;
      end
   end

   // nothing younger than a halt leaves decode
   assign issue = if_valid && legal && !load_stall && !flush && !halt_seen;

   always_ff @(posedge clk) begin
      if (rst) begin
         out.valid <= 1'b0;
         halt_seen <= 1'b0;
         err       <= 1'b0;
      end else begin
         if (if_valid && !legal && !flush && !halt_seen) begin
            err <= 1'b1;
         end
         if (!mem_stall) begin
            out.valid <= issue;
            if (issue && op == op_halt) begin
               halt_seen <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!mem_stall) begin
         out.op          <= op;
         out.rd          <= rd;
         out.rs          <= ra;
         out.rt          <= rb;
         out.a           <= rd_a;
         out.b           <= rd_b;
         out.imm         <= (op == op_lbi || op == op_beqz) ? imm9_ext : imm6_ext;
         out.pc_plus_two <= if_pc_plus_two;
         out.wb_src      <= wb_src;
         // filled in by execute
         out.result      <= '0;
      end else begin
         // held operands pick up a write that retires during the stall
         if (wb_valid && wb_dst == out.rs) begin
            out.a <= wb_data;
         end
         if (wb_valid && wb_dst == out.rt) begin
            out.b <= wb_data;
         end
      end
   end

endmodule

// File: source/fetch.sv
// ###################
// instruction fetch
// program counter and IF/ID register
// ###################
`timescale 1ns/1ps

module fetch
   import cpu16_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              stall,
   input  logic              flush,
   input  logic [data_w-1:0] redirect_pc,
   input  logic              halt,
   input  logic [data_w-1:0] imem_data,
   output logic [data_w-1:0] imem_addr,
   output logic              if_valid,
   output logic [data_w-1:0] if_instr,
   output logic [data_w-1:0] if_pc_plus_two
);

   logic [data_w-1:0] pc;
   logic [data_w-1:0] pc_plus_two;
   logic              advance;

   assign pc_plus_two = pc + 16'd2;
   assign imem_addr   = pc;
   assign advance     = !stall && !halt;

   // branch redirect wins over a held pc
   always_ff @(posedge clk) begin
      if (rst) begin
         pc       <= '0;
         if_valid <= 1'b0;
      end else if (flush) begin
         pc       <= redirect_pc;
         if_valid <= 1'b0;
      end else if (advance) begin
         pc       <= pc_plus_two;
         if_valid <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         if_instr       <= imem_data;
         if_pc_plus_two <= pc_plus_two;
      end
   end

endmodule

// File: source/stage_if.sv
// ###################
// stage bundle
// one in-flight instruction between two pipeline stages
// ###################
`timescale 1ns/1ps

interface stage_if
   import cpu16_pkg::*;
();
   logic              valid;
   opcode_e           op;
   logic [reg_w-1:0]  rd;
   // rs and rt hold the register indices that were read into a and b
   logic [reg_w-1:0]  rs;
   logic [reg_w-1:0]  rt;
   logic [data_w-1:0] a;
   logic [data_w-1:0] b;
   logic [data_w-1:0] imm;
   logic [data_w-1:0] pc_plus_two;
   wb_src_e           wb_src;
   logic [data_w-1:0] result;

   modport src (output valid, op, rd, rs, rt, a, b, imm, pc_plus_two, wb_src, result);
   modport dst (input valid, op, rd, rs, rt, a, b, imm, pc_plus_two, wb_src, result);

endinterface

// File: source/cpu16_pkg.sv
// ###################
// cpu16 shared definitions
// opcodes, instruction field positions, widths and stage selects
// ###################

package cpu16_pkg;

   // datapath and register file sizes
   localparam int data_w    = 16;
   localparam int reg_count = 8;
   localparam int reg_w     = 3;

   // instruction field positions
   localparam int op_lsb = 12;
   localparam int op_w   = 4;
   localparam int rd_lsb = 9;
   localparam int rs_lsb = 6;
   localparam int rt_lsb = 3;
   localparam int imm6_w = 6;
   localparam int imm9_w = 9;

   // encodings 4'ha to 4'he are illegal
   typedef enum logic [op_w-1:0] {
      op_nop  = 4'h0,
      op_add  = 4'h1,
      op_sub  = 4'h2,
      op_and  = 4'h3,
      op_xor  = 4'h4,
      op_addi = 4'h5,
      op_lbi  = 4'h6,
      op_ld   = 4'h7,
      op_st   = 4'h8,
      op_beqz = 4'h9,
      op_halt = 4'hf
   } opcode_e;

   // what the write-back stage puts into the register file
   typedef enum logic [1:0] {
      wb_none,
      wb_alu,
      wb_mem
   } wb_src_e;

   // operand source picked by the forwarding logic in execute
   typedef enum logic [1:0] {
      fwd_reg,
      fwd_exmem,
      fwd_memwb
   } fwd_sel_e;

endpackage
